// ==== encoderSpeed_cfg.svh ====
`ifndef ENCODER_SPEED_CFG_SVH
`define ENCODER_SPEED_CFG_SVH

// ==============================
// encoder speed build settings
// ==============================

// number of quadrature channels (1 to 8)
`define NUM_CHANNELS 4

// edge counts and speed results
`define SPEED_WIDTH 16

// measurement window in CLOCK_50 cycles, board value is 500000
`define WINDOW_CYCLES 200

// host register address
`define ADDR_WIDTH 4

`endif

// ==== encoderSpeedPkg.sv ====
`include "encoderSpeed_cfg.svh"

package encoderSpeedPkg;

	// ==============================
	// shared data types
	// ==============================

	typedef logic [`SPEED_WIDTH-1:0] speed_t; // counts and halved sums

	// at least one bit even for a single channel
	typedef logic [$clog2((`NUM_CHANNELS > 1) ? `NUM_CHANNELS : 2)-1:0] chanId_t;

	// ==============================
	// enums
	// ==============================

	typedef enum logic {
		COUNTING, // nothing waiting
		PENDING   // result latched, waiting on credit
	} chanState_e;

	// host register map
	typedef enum logic [`ADDR_WIDTH-1:0] {
		SPEED_BASE  = `ADDR_WIDTH'(0), // channel n at SPEED_BASE + n
		DIR_REG     = `ADDR_WIDTH'(8), // one direction bit per channel
		OVERRUN_REG = `ADDR_WIDTH'(9)  // sticky overrun bits
	} regAddr_e;

endpackage

// ==== encoderIf.sv ====
`timescale 1ns/1ps

`include "encoderSpeed_cfg.svh"

// synchronized encoder events for one channel
interface encoderIf;

	logic riseA;     // one-cycle pulse per A rising edge
	logic riseB;     // one-cycle pulse per B rising edge
	logic levelB;    // B level, aligned with riseA
	logic windowEnd; // shared end-of-window strobe

	modport source (
		output riseA,
		output riseB,
		output levelB,
		output windowEnd
	);

	modport sink (
		input riseA,
		input riseB,
		input levelB,
		input windowEnd
	);

endinterface

// ==== speedIf.sv ====
`timescale 1ns/1ps

`include "encoderSpeed_cfg.svh"

// one channel's result path, credit flows back from the collector
interface speedIf;

	logic                    valid;     // one cycle, spends the credit
	encoderSpeedPkg::speed_t speed;
	logic                    direction;
	logic                    overrun;   // pending result was replaced
	logic                    credit;    // staging slot freed

	modport sender (
		output valid,
		output speed,
		output direction,
		output overrun,
		input  credit
	);

	modport receiver (
		input  valid,
		input  speed,
		input  direction,
		input  overrun,
		output credit
	);

endinterface

// ==== encoderFrontEnd.sv ====
`timescale 1ns/1ps

`include "encoderSpeed_cfg.svh"

module encoderFrontEnd (
	input  logic                     CLOCK_50,
	input  logic                     reset,
	input  logic [`NUM_CHANNELS-1:0] encA,
	input  logic [`NUM_CHANNELS-1:0] encB,
	encoderIf.source                 edges [`NUM_CHANNELS]
);

	localparam int WIN_W = $clog2(`WINDOW_CYCLES);

	logic [`NUM_CHANNELS-1:0] syncA1, syncA2, prevA;
	logic [`NUM_CHANNELS-1:0] syncB1, syncB2, prevB;
	logic [`NUM_CHANNELS-1:0] riseA, riseB;
	logic [WIN_W-1:0]         winCount;
	logic                     windowEnd;
	logic                     lastCycle;

	// ==============================
	// synchronizers and edge detect
	// ==============================

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			syncA1 <= '0;
			syncA2 <= '0;
			prevA  <= '0;
			syncB1 <= '0;
			syncB2 <= '0;
			prevB  <= '0;
			riseA  <= '0;
			riseB  <= '0;
		end else begin
			syncA1 <= encA;
			syncA2 <= syncA1;
			syncB1 <= encB;
			syncB2 <= syncB1;
			prevA  <= syncA2;
			prevB  <= syncB2; // doubles as the B level seen by the channel
			riseA  <= syncA2 & ~prevA; // pulse lands 3 cycles after the pin
			riseB  <= syncB2 & ~prevB;
		end
	end

	// ==============================
	// window timer
	// ==============================

	assign lastCycle = (winCount == WIN_W'(`WINDOW_CYCLES - 1));

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			winCount  <= '0;
			windowEnd <= 1'b0;
		end else begin
			windowEnd <= lastCycle;
			winCount  <= lastCycle ? '0 : winCount + 1'b1;
		end
	end

	// fan out to every channel
	for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : genEdges
		assign edges[i].riseA     = riseA[i];
		assign edges[i].riseB     = riseB[i];
		assign edges[i].levelB    = prevB[i];
		assign edges[i].windowEnd = windowEnd;
	end

	// strobe must stay a single pulse or channels latch twice
	assert property (@(posedge CLOCK_50) disable iff (reset) windowEnd |=> !windowEnd)
		else $error("encoderFrontEnd: windowEnd high two cycles in a row");

endmodule

// ==== speedChannel.sv ====
`timescale 1ns/1ps

`include "encoderSpeed_cfg.svh"

module speedChannel (
	input  logic   CLOCK_50,
	input  logic   reset,
	encoderIf.sink edges,
	speedIf.sender result
);

	encoderSpeedPkg::chanState_e state;
	encoderSpeedPkg::speed_t     countA;
	encoderSpeedPkg::speed_t     countB;
	encoderSpeedPkg::speed_t     speedHold;
	logic [`SPEED_WIDTH:0]       edgeSum;   // one extra bit so the sum never wraps
	logic                        dirNow;
	logic                        dirHold;
	logic [1:0]                  creditCount;
	logic                        sendNow;

	assign edgeSum = {1'b0, countA} + {1'b0, countB};
	assign sendNow = (state == encoderSpeedPkg::PENDING) && (creditCount != 2'd0);

	assign result.valid     = sendNow;
	assign result.speed     = speedHold;
	assign result.direction = dirHold;
	// a pending result that never left gets replaced
	assign result.overrun   = edges.windowEnd && (state == encoderSpeedPkg::PENDING) && !sendNow;

	// ==============================
	// edge counters and direction
	// ==============================

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			countA <= '0;
			countB <= '0;
			dirNow <= 1'b0;
		end else begin
			if (edges.windowEnd) begin
				// edges in the strobe cycle belong to the new window
				countA <= `SPEED_WIDTH'(edges.riseA);
				countB <= `SPEED_WIDTH'(edges.riseB);
			end else begin
				countA <= countA + `SPEED_WIDTH'(edges.riseA);
				countB <= countB + `SPEED_WIDTH'(edges.riseB);
			end
			if (edges.riseA)
				dirNow <= edges.levelB; // B level at the latest A rise
		end
	end

	// result latch
	always_ff @(posedge CLOCK_50) begin
		if (edges.windowEnd) begin
			speedHold <= edgeSum[`SPEED_WIDTH:1]; // floor of sum / 2
			dirHold   <= dirNow;
		end
	end

	// ==============================
	// state and credit
	// ==============================

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			state       <= encoderSpeedPkg::COUNTING;
			creditCount <= 2'd1; // one slot waiting in the collector
		end else begin
			if (edges.windowEnd)
				state <= encoderSpeedPkg::PENDING;
			else if (sendNow)
				state <= encoderSpeedPkg::COUNTING;

			case ({result.credit, sendNow})
				2'b10:   creditCount <= creditCount + 2'd1;
				2'b01:   creditCount <= creditCount - 2'd1;
				default: creditCount <= creditCount;
			endcase
		end
	end

	// collector must not hand back a credit that was never spent
	assert property (@(posedge CLOCK_50) disable iff (reset) creditCount <= 2'd1)
		else $error("speedChannel: more than one credit held");

	assert property (@(posedge CLOCK_50) disable iff (reset)
		result.valid |=> (creditCount == 2'd0) && ($past(creditCount) == 2'd1))
		else $error("speedChannel: valid sent without a held credit");

endmodule

// ==== speedCollector.sv ====
`timescale 1ns/1ps

`include "encoderSpeed_cfg.svh"

module speedCollector (
	input  logic                     CLOCK_50,
	input  logic                     reset,
	speedIf.receiver                 results [`NUM_CHANNELS],
	input  logic                     freeze,
	input  logic [`ADDR_WIDTH-1:0]   readAddr,
	output encoderSpeedPkg::speed_t  readData,
	output logic                     sampleReady
);

	logic [`NUM_CHANNELS-1:0] validIn, dirIn, overrunIn;
	encoderSpeedPkg::speed_t  speedIn   [`NUM_CHANNELS];
	encoderSpeedPkg::speed_t  slotSpeed [`NUM_CHANNELS];
	logic [`NUM_CHANNELS-1:0] slotDir, slotFull;
	encoderSpeedPkg::speed_t  speedReg  [`NUM_CHANNELS];
	logic [`NUM_CHANNELS-1:0] dirReg, overrunReg;
	logic [`NUM_CHANNELS-1:0] drainMask, doneMask;
	encoderSpeedPkg::chanId_t rrPtr;
	logic [`ADDR_WIDTH-1:0]   speedIdx;
	logic                     batchDone;

	for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : genPort
		assign validIn[i]        = results[i].valid;
		assign speedIn[i]        = results[i].speed;
		assign dirIn[i]          = results[i].direction;
		assign overrunIn[i]      = results[i].overrun;
		assign results[i].credit = drainMask[i]; // credit back as the slot empties

		assert property (@(posedge CLOCK_50) disable iff (reset) validIn[i] |-> !slotFull[i])
			else $error("speedCollector: result arrived on a full slot");
	end

	// ==============================
	// staging and round-robin drain
	// ==============================

	always_comb begin
		for (int n = 0; n < `NUM_CHANNELS; n++)
			drainMask[n] = !freeze && slotFull[n] && (rrPtr == encoderSpeedPkg::chanId_t'(n));
	end

	assign batchDone = (|drainMask) && (&(doneMask | drainMask));

	always_ff @(posedge CLOCK_50) begin
		for (int n = 0; n < `NUM_CHANNELS; n++) begin
			if (validIn[n]) begin
				slotSpeed[n] <= speedIn[n];
				slotDir[n]   <= dirIn[n];
			end
		end
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			slotFull    <= '0;
			dirReg      <= '0;
			overrunReg  <= '0;
			doneMask    <= '0;
			rrPtr       <= '0;
			sampleReady <= 1'b0;
			for (int n = 0; n < `NUM_CHANNELS; n++)
				speedReg[n] <= '0;
		end else begin
			for (int n = 0; n < `NUM_CHANNELS; n++) begin
				if (drainMask[n]) begin
					slotFull[n] <= 1'b0;
					speedReg[n] <= slotSpeed[n];
					dirReg[n]   <= slotDir[n];
				end
				if (validIn[n])
					slotFull[n] <= 1'b1;
			end
			overrunReg  <= overrunReg | overrunIn; // sticky until reset
			doneMask    <= batchDone ? '0 : (doneMask | drainMask);
			sampleReady <= batchDone;
			if (!freeze)
				rrPtr <= (rrPtr == encoderSpeedPkg::chanId_t'(`NUM_CHANNELS - 1)) ? '0 : rrPtr + 1'b1;
		end
	end

	// ==============================
	// host read port
	// ==============================

	assign speedIdx = readAddr - `ADDR_WIDTH'(encoderSpeedPkg::SPEED_BASE);

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			readData <= '0;
		end else begin
			case (readAddr)
				encoderSpeedPkg::DIR_REG:     readData <= `SPEED_WIDTH'(dirReg);
				encoderSpeedPkg::OVERRUN_REG: readData <= `SPEED_WIDTH'(overrunReg);
				default: begin
					if (speedIdx < `ADDR_WIDTH'(`NUM_CHANNELS))
						readData <= speedReg[encoderSpeedPkg::chanId_t'(speedIdx)];
					else
						readData <= '0; // unmapped
				end
			endcase
		end
	end

endmodule

// ==== encoderSpeedTop.sv ====
`timescale 1ns/1ps

`include "encoderSpeed_cfg.svh"

module encoderSpeedTop (
	input  logic                     CLOCK_50,
	input  logic                     reset,
	input  logic [`NUM_CHANNELS-1:0] encA,
	input  logic [`NUM_CHANNELS-1:0] encB,
	input  logic                     freeze,      // host holds off the drain
	input  logic [`ADDR_WIDTH-1:0]   readAddr,
	output logic [`SPEED_WIDTH-1:0]  readData,
	output logic                     sampleReady
);

	encoderIf edgeBus   [`NUM_CHANNELS] ();
	speedIf   resultBus [`NUM_CHANNELS] ();

	// ==============================
	// front end, channels, collector
	// ==============================

	encoderFrontEnd frontEnd (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.encA     (encA),
		.encB     (encB),
		.edges    (edgeBus)
	);

	for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : genChannel
		speedChannel channel (
			.CLOCK_50 (CLOCK_50),
			.reset    (reset),
			.edges    (edgeBus[i]),
			.result   (resultBus[i])
		);
	end

	speedCollector collector (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.results     (resultBus),
		.freeze      (freeze),
		.readAddr    (readAddr),
		.readData    (readData),
		.sampleReady (sampleReady)
	);

endmodule

// ==== tb_encoderSpeed.sv ====
`timescale 1ns/1ps

`include "encoderSpeed_cfg.svh"

module tb_encoderSpeed;

	localparam int NCH         = `NUM_CHANNELS;
	localparam int WIN         = `WINDOW_CYCLES;
	localparam int NUM_TESTS   = 5;
	localparam int CYCLE_LIMIT = 12 * WIN * NUM_TESTS;

	logic                    CLOCK_50;
	logic                    reset;
	logic [NCH-1:0]          encA;
	logic [NCH-1:0]          encB;
	logic                    freeze;
	logic [`ADDR_WIDTH-1:0]  readAddr;
	logic [`SPEED_WIDTH-1:0] readData;
	logic                    sampleReady;

	int errorCount;
	int checkCount;
	int testsPassed;
	int testsFailed;
	int cycleCount;
	int testErrStart;
	int kA [NCH]; // A rises per channel in the next burst
	int kB [NCH];

	encoderSpeedTop dut_i (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.encA        (encA),
		.encB        (encB),
		.freeze      (freeze),
		.readAddr    (readAddr),
		.readData    (readData),
		.sampleReady (sampleReady)
	);

	always #50 CLOCK_50 = ~CLOCK_50;

	// run guard
	always @(posedge CLOCK_50) begin
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test FAILED");
			$finish;
		end else begin
			cycleCount <= cycleCount + 1;
		end
	end

	// ==============================
	// helpers
	// ==============================

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	// data is registered, valid one cycle after the address
	task automatic readRegister(input logic [`ADDR_WIDTH-1:0] addr,
		output logic [`SPEED_WIDTH-1:0] value);
		readAddr = addr;
		@(negedge CLOCK_50);
		value = readData;
	endtask

	task automatic waitForSample();
		int waited;
		waited = 0;
		@(negedge CLOCK_50); // never reuse the pulse already seen
		while (sampleReady !== 1'b1 && waited < 2 * WIN) begin
			@(negedge CLOCK_50);
			waited++;
		end
		if (sampleReady !== 1'b1) begin
			errorCount++;
			$display("sampleReady did not pulse within %0d cycles", 2 * WIN);
		end
	endtask

	// 2 high, 2 low per pulse, all channels in parallel
	task automatic driveBursts(input logic [NCH-1:0] holdB);
		int most;
		int c;
		int i;
		most = 0;
		for (c = 0; c < NCH; c++) begin
			if (kA[c] > most) most = kA[c];
			if (kB[c] > most) most = kB[c];
		end
		for (i = 0; i < most; i++) begin
			for (c = 0; c < NCH; c++) begin
				encA[c] = (i < kA[c]);
				encB[c] = holdB[c] | (i < kB[c]);
			end
			repeat (2) @(negedge CLOCK_50);
			encA = '0;
			encB = holdB;
			repeat (2) @(negedge CLOCK_50);
		end
	endtask

	task automatic pickCounts(input int lo, input int hi);
		int c;
		for (c = 0; c < NCH; c++) begin
			kA[c] = $urandom_range(hi, lo);
			kB[c] = $urandom_range(hi, lo);
		end
	endtask

	// speed is floor of (A rises + B rises) / 2
	task automatic checkAllSpeeds();
		logic [`SPEED_WIDTH-1:0] value;
		int c;
		for (c = 0; c < NCH; c++) begin
			readRegister(`ADDR_WIDTH'(c), value);
			compareValue($sformatf("speed[%0d]", c), value, (kA[c] + kB[c]) / 2);
		end
	endtask

	task automatic finishTest(input string name);
		if (errorCount == testErrStart) begin
			testsPassed++;
			$display("[%0t] %s: passed", $time, name);
		end else begin
			testsFailed++;
			$display("[%0t] %s: %0d errors", $time, name, errorCount - testErrStart);
		end
		testErrStart = errorCount;
	endtask

	// ==============================
	// directed tests
	// ==============================

	task automatic resetValues();
		logic [`SPEED_WIDTH-1:0] value;
		int a;
		for (a = 0; a < (1 << `ADDR_WIDTH); a++) begin
			readRegister(`ADDR_WIDTH'(a), value);
			compareValue($sformatf("readData@%0d", a), value, 0);
			compareValue("sampleReady", sampleReady, 0); // first window still open
		end
	endtask

	task automatic equalBursts();
		int k;
		int c;
		k = $urandom_range(20, 1);
		for (c = 0; c < NCH; c++) begin
			kA[c] = 0;
			kB[c] = 0;
		end
		kA[0] = k;
		kB[0] = k;
		waitForSample();
		driveBursts('0);
		waitForSample();
		checkAllSpeeds();
	endtask

	task automatic unequalChannels();
		logic [`SPEED_WIDTH-1:0] value;
		pickCounts(0, 20);
		waitForSample();
		driveBursts('0);
		waitForSample();
		checkAllSpeeds();
		readRegister(encoderSpeedPkg::OVERRUN_REG, value);
		compareValue("overrun", value, 0);
	endtask

	task automatic directionHold();
		logic [`SPEED_WIDTH-1:0] value;
		logic [NCH-1:0]          dirBits;
		logic                    flip;
		int c;
		flip = 1'($urandom);
		for (c = 0; c < NCH; c++) begin
			dirBits[c] = flip ^ c[0]; // neighbours differ
			kA[c] = $urandom_range(5, 1);
			kB[c] = 0;
		end
		waitForSample();
		encB = dirBits; // settle B before any A rise
		repeat (4) @(negedge CLOCK_50);
		driveBursts(dirBits);
		encB = '0;
		for (c = 0; c < NCH; c++)
			kB[c] = dirBits[c]; // one B rise where held high
		waitForSample();
		checkAllSpeeds();
		readRegister(encoderSpeedPkg::DIR_REG, value);
		compareValue("direction", value, dirBits);

		// B only, so no A rise in this window
		for (c = 0; c < NCH; c++) begin
			kA[c] = 0;
			kB[c] = $urandom_range(5, 1);
		end
		driveBursts('0);
		waitForSample();
		checkAllSpeeds();
		readRegister(encoderSpeedPkg::DIR_REG, value);
		compareValue("direction kept", value, dirBits);
	endtask

	task automatic freezeOverrun();
		logic [`SPEED_WIDTH-1:0] value;
		int oldA [NCH];
		int oldB [NCH];
		int c;
		pickCounts(1, 20);
		waitForSample();
		driveBursts('0);
		waitForSample();
		checkAllSpeeds();
		oldA = kA;
		oldB = kB;

		freeze = 1'b1;
		for (c = 0; c < NCH; c++) begin
			kA[c] = 1;
			kB[c] = 1;
		end
		driveBursts('0);
		repeat (3 * WIN) @(negedge CLOCK_50); // third window end replaces pending
		kA = oldA;
		kB = oldB;
		checkAllSpeeds();
		readRegister(encoderSpeedPkg::OVERRUN_REG, value);
		compareValue("overrun frozen", value, (1 << NCH) - 1);

		freeze = 1'b0;
		waitForSample(); // staged slots drain
		waitForSample(); // then the replaced pending results
		pickCounts(1, 20);
		driveBursts('0);
		waitForSample();
		checkAllSpeeds();
		readRegister(encoderSpeedPkg::OVERRUN_REG, value);
		compareValue("overrun sticky", value, (1 << NCH) - 1);
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial begin
		void'($urandom(82));
		CLOCK_50     = 1'b0;
		reset        = 1'b1;
		encA         = '0;
		encB         = '0;
		freeze       = 1'b0;
		readAddr     = '0;
		errorCount   = 0;
		checkCount   = 0;
		testsPassed  = 0;
		testsFailed  = 0;
		cycleCount   = 0;
		testErrStart = 0;
		repeat (16) @(negedge CLOCK_50);
		reset = 1'b0;

		resetValues();
		finishTest("reset values");
		equalBursts();
		finishTest("equal bursts");
		unequalChannels();
		finishTest("unequal channels");
		directionHold();
		finishTest("direction hold");
		freezeOverrun();
		finishTest("freeze and overrun");

		$display("tests %0d passed %0d failed %0d checks %0d errors %0d",
			NUM_TESTS, testsPassed, testsFailed, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
encoderSpeedPkg.sv
encoderIf.sv
speedIf.sv
encoderFrontEnd.sv
speedChannel.sv
speedCollector.sv
encoderSpeedTop.sv
tb_encoderSpeed.sv

// ==== run.sh ====
#!/bin/sh
# build and run the encoder speed testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_encoderSpeed -o simv
./obj_dir/simv | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished cleanly"
exit 0
